//--- design/cache_geom_pkg.sv
// Cache geometry, controller state codes and the address view shared by
// the cache controller and its tag/data store.
// Modules take it with a wildcard import in their header.

`default_nettype none

package cache_geom_pkg;

        // Geometry --------------------
        localparam int LINE_WORDS = 4;          // 32-bit words per line
        localparam int NUM_LINES  = 16;
        localparam int OFFSET_W   = 2;          // Word select
        localparam int INDEX_W    = 4;          // Line select
        localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;
        localparam int LINE_W     = LINE_WORDS * 32;
        localparam int BEN_W      = LINE_WORDS * 4;

        // Controller states --------------------
        localparam logic [2:0] ST_IDLE = 3'd0;
        localparam logic [2:0] ST_UNC  = 3'd1;  // Single uncached beat
        localparam logic [2:0] ST_WB   = 3'd2;  // Victim write-back burst
        localparam logic [2:0] ST_FILL = 3'd3;  // Line fill burst
        localparam logic [2:0] ST_INV  = 3'd4;

        // Processor address, whole or split for the lookup
        typedef union packed
        {
                logic [31:0] full;
                struct packed
                {
                        logic [TAG_W-1:0]    tag;
                        logic [INDEX_W-1:0]  index;
                        logic [OFFSET_W-1:0] offset;
                        logic [1:0]          byte_sel;
                } f;
        } cache_addr_u;

endpackage

`default_nettype wire

//--- design/wb_pkg.sv
// Wishbone cycle-type codes and bus widths for the cache bus master.
// Modules take it with a wildcard import in their header.

`default_nettype none

package wb_pkg;

        localparam logic [2:0] CTI_CLASSIC = 3'b000;
        localparam logic [2:0] CTI_BURST   = 3'b010;   // Incrementing burst
        localparam logic [2:0] CTI_EOB     = 3'b111;   // Last beat of a burst

        localparam int                  WB_SEL_W   = 4;
        localparam logic [WB_SEL_W-1:0] WB_SEL_ALL = '1;

endpackage

`default_nettype wire

//--- design/store_if.sv
// Controller to tag/data store connection.
// Reads are combinational from the address index, writes land at the clock edge.

`timescale 1ns/1ps
`default_nettype none

interface store_if
        import cache_geom_pkg::*;
();
        cache_addr_u            addr;           // Lookup address
        logic                   wr_en;          // Tag, dirty and enabled bytes
        logic [BEN_W-1:0]       line_ben;
        logic [LINE_W-1:0]      wr_line;
        logic [TAG_W-1:0]       wr_tag;
        logic                   wr_dirty;
        logic                   inv;            // Clears every valid bit
        logic [TAG_W-1:0]       rd_tag;
        logic                   rd_valid;
        logic                   rd_dirty;
        logic [LINE_W-1:0]      rd_line;

        modport ctrl
        (
                output addr, wr_en, line_ben, wr_line, wr_tag, wr_dirty, inv,
                input  rd_tag, rd_valid, rd_dirty, rd_line
        );

        modport store
        (
                input  addr, wr_en, line_ben, wr_line, wr_tag, wr_dirty, inv,
                output rd_tag, rd_valid, rd_dirty, rd_line
        );
endinterface

`default_nettype wire

//--- design/wb_req_if.sv
// Controller to Wishbone beat engine connection.
// One issue pulse per beat, answered by a done pulse with the read data.

`timescale 1ns/1ps
`default_nettype none

interface wb_req_if
        import wb_pkg::*;
();
        logic                   issue;
        logic                   we;
        logic [31:0]            adr;
        logic [31:0]            dat;
        logic [WB_SEL_W-1:0]    sel;
        logic [2:0]             cti;
        logic                   done;           // Follows the bus ack
        logic [31:0]            rdat;

        modport ctrl (output issue, we, adr, dat, sel, cti, input done, rdat);
        modport bus  (input issue, we, adr, dat, sel, cti, output done, rdat);
endinterface

`default_nettype wire

//--- design/line_store.sv
// Direct-mapped tag, valid, dirty and line storage for the data cache.
// Combinational read at the requested index, byte-enabled line write.

`timescale 1ns/1ps
`default_nettype none

module line_store
        import cache_geom_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_reset,
        store_if.store  s
);

logic [NUM_LINES-1:0]   valid_q;
logic [NUM_LINES-1:0]   dirty_q;
logic [TAG_W-1:0]       tag_q  [NUM_LINES];
logic [LINE_W-1:0]      line_q [NUM_LINES];
logic [INDEX_W-1:0]     idx;

assign idx        = s.addr.f.index;
assign s.rd_valid = valid_q[idx];
assign s.rd_dirty = dirty_q[idx];
assign s.rd_tag   = tag_q[idx];
assign s.rd_line  = line_q[idx];

// Status bits --------------------
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid_q <= '0;
                dirty_q <= '0;
        end
        else if (s.inv)
                valid_q <= '0;
        else if (s.wr_en)
        begin
                valid_q[idx] <= 1'b1;           // Any line write validates
                dirty_q[idx] <= s.wr_dirty;
        end
end

// Tag and data arrays --------------------
always_ff @(posedge i_clk)
begin
        if (s.wr_en)
        begin
                tag_q[idx] <= s.wr_tag;
                for (int b = 0; b < BEN_W; b++)
                begin
                        if (s.line_ben[b])
                                line_q[idx][b*8 +: 8] <= s.wr_line[b*8 +: 8];
                end
        end
end

// Controller never writes a line while invalidating
assert property (@(posedge i_clk) disable iff (i_reset) !(s.wr_en && s.inv));

endmodule

`default_nettype wire

//--- design/wb_master.sv
// Registered Wishbone master for the cache controller.
// Each issued beat is held on the bus until ack, then reported as done.

`timescale 1ns/1ps
`default_nettype none

module wb_master
        import wb_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        wb_req_if.bus                   r,
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic                    o_wb_we,
        output logic [31:0]             o_wb_adr,
        output logic [31:0]             o_wb_dat,
        output logic [WB_SEL_W-1:0]     o_wb_sel,
        output logic [2:0]              o_wb_cti,
        input  logic                    i_wb_ack,
        input  logic [31:0]             i_wb_dat
);

assign r.done = o_wb_stb && i_wb_ack;
assign r.rdat = i_wb_dat;

// A back-to-back issue keeps cyc up through a burst
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we  <= 1'b0;
                o_wb_cti <= CTI_CLASSIC;
        end
        else if (r.issue)
        begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                o_wb_we  <= r.we;
                o_wb_cti <= r.cti;
        end
        else if (r.done)
        begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_cti <= CTI_CLASSIC;
        end
end

always_ff @(posedge i_clk)
begin
        if (r.issue)
        begin
                o_wb_adr <= r.adr;
                o_wb_dat <= r.dat;
                o_wb_sel <= r.sel;
        end
end

// One beat in flight at a time
assert property (@(posedge i_clk) disable iff (i_reset)
        r.issue |-> !o_wb_stb || i_wb_ack);

// A waiting beat keeps cyc, stb and its address until ack
assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_stb && !i_wb_ack |=> o_wb_cyc && o_wb_stb && $stable(o_wb_adr));

endmodule

`default_nettype wire

//--- design/cache_fsm.sv
// Write-back data cache controller.
// Answers hits in the request cycle. A miss is acked with retry while the
// victim is written back and the line is filled by Wishbone bursts.

`timescale 1ns/1ps
`default_nettype none

module cache_fsm
        import cache_geom_pkg::*;
        import wb_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_rd,
        input  logic                    i_wr,
        input  logic [31:0]             i_address,
        input  logic [31:0]             i_din,
        input  logic [WB_SEL_W-1:0]     i_ben,
        input  logic                    i_cache_en,
        input  logic                    i_cache_inv,
        output logic [31:0]             o_dat,
        output logic                    o_ack,
        output logic                    o_retry,
        output logic                    o_idle,
        output logic                    o_cache_inv_done,
        store_if.ctrl                   s,
        wb_req_if.ctrl                  r
);

logic [2:0]             state_q, state_d;
logic [OFFSET_W:0]      ctr_q, ctr_d;   // Reaches LINE_WORDS once the fill is in
logic [LINE_W-1:0]      buf_q;
cache_addr_u            req_q;
logic                   wr_q;
logic [31:0]            din_q;
logic [WB_SEL_W-1:0]    ben_q;
cache_addr_u            cur;
logic                   req;
logic                   hit;
logic [OFFSET_W-1:0]    beat_w;
logic [LINE_W-1:0]      fill_line;

// Word address of a line beat with the index taken from the base
function automatic logic [31:0] line_adr(input cache_addr_u base,
                                         input logic [TAG_W-1:0] tag,
                                         input logic [OFFSET_W-1:0] w);
        cache_addr_u a;
        a            = base;
        a.f.tag      = tag;
        a.f.offset   = w;
        a.f.byte_sel = 2'b00;
        return a.full;
endfunction

assign req      = i_rd | i_wr;
assign o_idle   = (state_q == ST_IDLE);
assign cur.full = o_idle ? i_address : req_q.full;     // Latched once busy
assign s.addr   = cur;
assign hit      = s.rd_valid && (s.rd_tag == cur.f.tag);
assign beat_w   = ctr_q[OFFSET_W-1:0] + 1'b1;

// Pending write merged over the fetched words
always_comb
begin
        fill_line = buf_q;
        for (int b = 0; b < WB_SEL_W; b++)
        begin
                if (wr_q && ben_q[b])
                        fill_line[req_q.f.offset*32 + b*8 +: 8] = din_q[b*8 +: 8];
        end
end

// Next state and outputs --------------------
always_comb
begin
        state_d          = state_q;
        ctr_d            = ctr_q;
        o_ack            = 1'b0;
        o_retry          = 1'b0;
        o_cache_inv_done = 1'b0;
        o_dat            = s.rd_line[cur.f.offset*32 +: 32];
        s.wr_en          = 1'b0;
        s.line_ben       = '0;
        s.wr_line        = fill_line;
        s.wr_tag         = req_q.f.tag;
        s.wr_dirty       = wr_q;
        s.inv            = 1'b0;
        r.issue          = 1'b0;
        r.we             = 1'b0;
        r.adr            = line_adr(cur, cur.f.tag, '0);       // First fill beat
        r.dat            = s.rd_line[31:0];
        r.sel            = WB_SEL_ALL;
        r.cti            = CTI_BURST;

        case (state_q)
        ST_IDLE:
        begin
                if (i_cache_inv)
                        state_d = ST_INV;
                else if (req && !i_cache_en)
                begin
                        r.issue = 1'b1;
                        r.we    = i_wr;
                        r.adr   = i_address;
                        r.dat   = i_din;
                        r.sel   = i_ben;
                        r.cti   = CTI_CLASSIC;
                        state_d = ST_UNC;
                end
                else if (req && hit)
                begin
                        o_ack      = 1'b1;
                        s.wr_en    = i_wr;
                        s.line_ben = BEN_W'(i_ben) << (cur.f.offset * WB_SEL_W);
                        s.wr_line  = {LINE_WORDS{i_din}};
                        s.wr_tag   = cur.f.tag;
                        s.wr_dirty = 1'b1;
                end
                else if (req)
                begin
                        o_ack   = 1'b1;
                        o_retry = 1'b1;
                        r.issue = 1'b1;
                        ctr_d   = '0;
                        if (s.rd_valid && s.rd_dirty)
                        begin
                                r.we    = 1'b1;
                                r.adr   = line_adr(cur, s.rd_tag, '0);
                                state_d = ST_WB;
                        end
                        else
                                state_d = ST_FILL;
                end
        end

        ST_UNC:
        begin
                o_dat = r.rdat;
                if (r.done)
                begin
                        o_ack   = 1'b1;
                        state_d = ST_IDLE;
                end
        end

        ST_WB:
        begin
                o_ack   = req;
                o_retry = req;
                if (r.done && ctr_q == LINE_WORDS - 1)
                begin
                        s.wr_en    = 1'b1;      // Victim now clean before the fill
                        s.wr_tag   = s.rd_tag;
                        s.wr_dirty = 1'b0;
                        r.issue    = 1'b1;
                        ctr_d      = '0;
                        state_d    = ST_FILL;
                end
                else if (r.done)
                begin
                        r.issue = 1'b1;
                        r.we    = 1'b1;
                        r.adr   = line_adr(cur, s.rd_tag, beat_w);
                        r.dat   = s.rd_line[beat_w*32 +: 32];
                        r.cti   = (beat_w == OFFSET_W'(LINE_WORDS - 1)) ? CTI_EOB : CTI_BURST;
                        ctr_d   = ctr_q + 1'b1;
                end
        end

        ST_FILL:
        begin
                o_ack   = req;
                o_retry = req;
                if (ctr_q == LINE_WORDS)
                begin
                        s.wr_en    = 1'b1;
                        s.line_ben = '1;
                        state_d    = ST_IDLE;
                end
                else if (r.done)
                begin
                        ctr_d = ctr_q + 1'b1;
                        if (ctr_q != LINE_WORDS - 1)
                        begin
                                r.issue = 1'b1;
                                r.adr   = line_adr(cur, cur.f.tag, beat_w);
                                r.cti   = (beat_w == OFFSET_W'(LINE_WORDS - 1)) ?
                                          CTI_EOB : CTI_BURST;
                        end
                end
        end

        ST_INV:
        begin
                o_ack            = req;
                o_retry          = req;
                s.inv            = 1'b1;
                o_cache_inv_done = 1'b1;
                state_d          = ST_IDLE;
        end

        default:
                state_d = ST_IDLE;
        endcase
end

// Registers --------------------
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q <= ST_IDLE;
                ctr_q   <= '0;
        end
        else
        begin
                state_q <= state_d;
                ctr_q   <= ctr_d;
        end
end

always_ff @(posedge i_clk)
begin
        if (o_idle)
        begin
                req_q <= cur;
                wr_q  <= i_wr;
                din_q <= i_din;
                ben_q <= i_ben;
        end
        if (state_q == ST_FILL && r.done)
                buf_q[ctr_q[OFFSET_W-1:0]*32 +: 32] <= r.rdat;
end

// An ack without retry ends the access and leaves the controller idle
assert property (@(posedge i_clk) disable iff (i_reset)
        o_ack && !o_retry |=> o_idle);

endmodule

`default_nettype wire

//--- design/cache_top.sv
// Data cache top level with processor and Wishbone master ports.
// Joins the controller, the line store and the bus beat engine.

`timescale 1ns/1ps
`default_nettype none

module cache_top
        import wb_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        // Processor side
        input  logic                    i_rd,
        input  logic                    i_wr,
        input  logic [31:0]             i_address,
        input  logic [31:0]             i_din,
        input  logic [WB_SEL_W-1:0]     i_ben,
        input  logic                    i_cache_en,
        input  logic                    i_cache_inv,
        output logic [31:0]             o_dat,
        output logic                    o_ack,
        output logic                    o_retry,
        output logic                    o_idle,
        output logic                    o_cache_inv_done,
        // Wishbone side
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic                    o_wb_we,
        output logic [31:0]             o_wb_adr,
        output logic [31:0]             o_wb_dat,
        output logic [WB_SEL_W-1:0]     o_wb_sel,
        output logic [2:0]              o_wb_cti,
        input  logic                    i_wb_ack,
        input  logic [31:0]             i_wb_dat
);

store_if  u_store_if ();
wb_req_if u_req_if ();

cache_fsm u_fsm
(
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_rd             (i_rd),
        .i_wr             (i_wr),
        .i_address        (i_address),
        .i_din            (i_din),
        .i_ben            (i_ben),
        .i_cache_en       (i_cache_en),
        .i_cache_inv      (i_cache_inv),
        .o_dat            (o_dat),
        .o_ack            (o_ack),
        .o_retry          (o_retry),
        .o_idle           (o_idle),
        .o_cache_inv_done (o_cache_inv_done),
        .s                (u_store_if.ctrl),
        .r                (u_req_if.ctrl)
);

line_store u_store
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .s       (u_store_if.store)
);

wb_master u_wb
(
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .r        (u_req_if.bus),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat),
        .o_wb_sel (o_wb_sel),
        .o_wb_cti (o_wb_cti),
        .i_wb_ack (i_wb_ack),
        .i_wb_dat (i_wb_dat)
);

endmodule

`default_nettype wire

//--- dv/tb_cache.sv
// Testbench for the write-back data cache.
// Holds a Wishbone memory model, a processor request driver, a shadow memory
// reference and a bus monitor. Run through the Makefile in the project root.

`timescale 1ns/1ps
`default_nettype none

module tb_cache
        import cache_geom_pkg::*;
        import wb_pkg::*;
();

localparam int CLK_HALF     = 20;
localparam int REQ_LIMIT    = 200;      // Cycles allowed for one access
localparam int NUM_ACCESSES = 30;       // Accesses and invalidates over all tests
localparam int ACCESS_BOUND = 40;       // Cycles per access for the watchdog

logic                   i_clk;
logic                   i_reset;
logic                   i_rd;
logic                   i_wr;
logic [31:0]            i_address;
logic [31:0]            i_din;
logic [WB_SEL_W-1:0]    i_ben;
logic                   i_cache_en;
logic                   i_cache_inv;
logic [31:0]            o_dat;
logic                   o_ack;
logic                   o_retry;
logic                   o_idle;
logic                   o_cache_inv_done;
logic                   o_wb_cyc;
logic                   o_wb_stb;
logic                   o_wb_we;
logic [31:0]            o_wb_adr;
logic [31:0]            o_wb_dat;
logic [WB_SEL_W-1:0]    o_wb_sel;
logic [2:0]             o_wb_cti;
logic                   i_wb_ack = 1'b0;
logic [31:0]            i_wb_dat = '0;

logic [31:0]            mem    [256];   // 1 KB behind the bus
logic [31:0]            shadow [256];   // Every processor write lands here
logic [31:0]            stim_lfsr  = 32'hefc7;
logic [31:0]            delay_lfsr = 32'hefc7;
logic                   beat_active = 1'b0;
logic [1:0]             wait_left   = '0;
int                     n_checks    = 0;
int                     n_errors    = 0;
int                     n_accesses  = 0;
logic [31:0]            mon_adr [$];
logic                   mon_we  [$];
logic [2:0]             mon_cti [$];
logic [WB_SEL_W-1:0]    mon_sel [$];

cache_top u_dut
(
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_rd             (i_rd),
        .i_wr             (i_wr),
        .i_address        (i_address),
        .i_din            (i_din),
        .i_ben            (i_ben),
        .i_cache_en       (i_cache_en),
        .i_cache_inv      (i_cache_inv),
        .o_dat            (o_dat),
        .o_ack            (o_ack),
        .o_retry          (o_retry),
        .o_idle           (o_idle),
        .o_cache_inv_done (o_cache_inv_done),
        .o_wb_cyc         (o_wb_cyc),
        .o_wb_stb         (o_wb_stb),
        .o_wb_we          (o_wb_we),
        .o_wb_adr         (o_wb_adr),
        .o_wb_dat         (o_wb_dat),
        .o_wb_sel         (o_wb_sel),
        .o_wb_cti         (o_wb_cti),
        .i_wb_ack         (i_wb_ack),
        .i_wb_dat         (i_wb_dat)
);

initial
        i_clk = 1'b0;
always #(CLK_HALF) i_clk = ~i_clk;

// Helpers --------------------
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
                state = lfsr_step(state);
                v     = {v[30:0], state[0]};
        end
endtask

function automatic logic [31:0] fill_word(input logic [7:0] w);
        return {w ^ 8'h5a, ~w, w, w + 8'h37};
endfunction

// Expected word at addr, with an optional write merged by byte enable
function automatic logic [31:0] ref_word(input logic [31:0] addr, input logic wr,
                                         input logic [31:0] din, input logic [3:0] ben);
        logic [31:0] w;
        w = shadow[addr[9:2]];
        for (int b = 0; b < 4; b++)
        begin
                if (wr && ben[b])
                        w[b*8 +: 8] = din[b*8 +: 8];
        end
        return w;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act)
        begin
                n_errors++;
                $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
endtask

task automatic clear_monitor();
        mon_adr.delete();
        mon_we.delete();
        mon_cti.delete();
        mon_sel.delete();
endtask

task automatic check_burst(input int first, input logic [31:0] base, input logic we);
        for (int k = 0; k < LINE_WORDS; k++)
        begin
                check_value("o_wb_adr", base + 4 * k, mon_adr[first + k]);
                check_value("o_wb_we", we, mon_we[first + k]);
                check_value("o_wb_cti", (k == LINE_WORDS - 1) ? CTI_EOB : CTI_BURST,
                            mon_cti[first + k]);
        end
endtask

// Holds the request until an ack without retry
task automatic cpu_access(input logic wr, input logic [31:0] addr, input logic [31:0] din,
                          input logic [3:0] ben, output int retries);
        int   cycles;
        logic done;
        @(negedge i_clk);
        i_rd      = !wr;
        i_wr      = wr;
        i_address = addr;
        i_din     = din;
        i_ben     = ben;
        retries   = 0;
        cycles    = 0;
        done      = 1'b0;
        while (!done && cycles < REQ_LIMIT)
        begin
                @(posedge i_clk);
                cycles++;
                if (o_ack && o_retry)
                        retries++;
                else if (o_ack)
                        done = 1'b1;
        end
        if (done && wr)
                shadow[addr[9:2]] = ref_word(addr, 1'b1, din, ben);
        if (!done)
        begin
                n_errors++;
                $display("Access to %h got no final ack within %0d cycles", addr, REQ_LIMIT);
        end
        n_accesses++;
        @(negedge i_clk);
        i_rd = 1'b0;
        i_wr = 1'b0;
endtask

task automatic end_test(input string name, input int errs_before);
        $display("%s: %0d errors", name, n_errors - errs_before);
endtask

// Memory model --------------------
always @(negedge i_clk)
begin
        logic [31:0] v;
        if (i_reset)
        begin
                i_wb_ack    = 1'b0;
                beat_active = 1'b0;
        end
        else if (i_wb_ack)
                i_wb_ack = 1'b0;                // Beat taken at the last edge
        else if (o_wb_cyc && o_wb_stb)
        begin
                if (!beat_active)
                begin
                        draw_bits(delay_lfsr, 2, v);
                        wait_left   = v[1:0];
                        beat_active = 1'b1;
                end
                if (wait_left == 0)
                begin
                        for (int b = 0; b < WB_SEL_W; b++)
                        begin
                                if (o_wb_we && o_wb_sel[b])
                                        mem[o_wb_adr[9:2]][b*8 +: 8] = o_wb_dat[b*8 +: 8];
                        end
                        i_wb_dat    = mem[o_wb_adr[9:2]];
                        i_wb_ack    = 1'b1;
                        beat_active = 1'b0;
                end
                else
                        wait_left = wait_left - 1'b1;
        end
end

// Bus monitor and read compare --------------------
always @(posedge i_clk)
begin
        if (o_wb_stb && i_wb_ack)
        begin
                mon_adr.push_back(o_wb_adr);
                mon_we.push_back(o_wb_we);
                mon_cti.push_back(o_wb_cti);
                mon_sel.push_back(o_wb_sel);
        end
end

always @(posedge i_clk)
begin
        if (!i_reset && i_rd && o_ack && !o_retry)
                check_value("o_dat", ref_word(i_address, 1'b0, '0, '0), o_dat);
end

initial
begin
        #(NUM_ACCESSES * ACCESS_BOUND * 2 * CLK_HALF);
        $display("Watchdog: run did not end within %0d cycles", NUM_ACCESSES * ACCESS_BOUND);
        $display(">>> FAIL");
        $finish;
end

// Tests --------------------
initial
begin
        int          retries;
        int          errs;
        logic        seen;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] b;
        i_reset     = 1'b1;
        i_rd        = 1'b0;
        i_wr        = 1'b0;
        i_address   = '0;
        i_din       = '0;
        i_ben       = '0;
        i_cache_en  = 1'b1;
        i_cache_inv = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
                mem[i]    = fill_word(i[7:0]);
                shadow[i] = mem[i];
        end
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        @(posedge i_clk);
        check_value("o_idle", 1, o_idle);
        check_value("o_wb_cyc", 0, o_wb_cyc);
        check_value("o_wb_stb", 0, o_wb_stb);
        check_value("o_ack", 0, o_ack);
        check_value("o_retry", 0, o_retry);
        check_value("o_cache_inv_done", 0, o_cache_inv_done);

        errs = n_errors;
        clear_monitor();
        cpu_access(1'b0, 32'h48, '0, 4'hf, retries);
        check_value("retry on miss", 1, retries != 0);
        check_value("fill beat count", LINE_WORDS, mon_adr.size());
        if (mon_adr.size() == LINE_WORDS)
                check_burst(0, 32'h40, 1'b0);
        clear_monitor();
        cpu_access(1'b0, 32'h48, '0, 4'hf, retries);
        check_value("retries on hit", 0, retries);
        check_value("beat count on hit", 0, mon_adr.size());
        end_test("test 1 read miss then hit", errs);

        errs = n_errors;
        cpu_access(1'b1, 32'h44, 32'hdead_beef, 4'b0011, retries);
        check_value("retries on write hit", 0, retries);
        cpu_access(1'b0, 32'h44, '0, 4'hf, retries);
        cpu_access(1'b1, 32'ha8, 32'h1234_5678, 4'b1100, retries);
        check_value("retry on write miss", 1, retries != 0);
        cpu_access(1'b0, 32'ha8, '0, 4'hf, retries);
        cpu_access(1'b0, 32'ha4, '0, 4'hf, retries);
        for (int k = 0; k < 8; k++)
        begin
                draw_bits(stim_lfsr, 7, a);
                draw_bits(stim_lfsr, 4, b);
                draw_bits(stim_lfsr, 32, d);
                a = {23'b0, a[6:0], 2'b00};     // Below 0x200, clear of tests 4 and 5
                if (b[3:0] == 4'h0)
                        b[3:0] = 4'hf;
                cpu_access(1'b1, a, d, b[3:0], retries);
                cpu_access(1'b0, a, '0, 4'hf, retries);
        end
        end_test("test 2 write hit and write miss", errs);

        errs = n_errors;
        cpu_access(1'b1, 32'hc4, 32'hc0ff_ee11, 4'hf, retries);
        clear_monitor();
        cpu_access(1'b0, 32'h1c4, '0, 4'hf, retries);   // Same index, other tag
        check_value("evict beat count", 2 * LINE_WORDS, mon_adr.size());
        if (mon_adr.size() == 2 * LINE_WORDS)
        begin
                check_burst(0, 32'hc0, 1'b1);
                check_burst(LINE_WORDS, 32'h1c0, 1'b0);
        end
        for (int k = 0; k < LINE_WORDS; k++)
                check_value("victim word", shadow[8'h30 + k], mem[8'h30 + k]);
        end_test("test 3 dirty eviction", errs);

        errs = n_errors;
        @(negedge i_clk);
        i_cache_en = 1'b0;
        clear_monitor();
        cpu_access(1'b1, 32'h300, 32'ha5a5_0f0f, 4'b0101, retries);
        check_value("uncached write beats", 1, mon_adr.size());
        if (mon_adr.size() == 1)
        begin
                check_value("o_wb_cti", CTI_CLASSIC, mon_cti[0]);
                check_value("o_wb_adr", 32'h300, mon_adr[0]);
                check_value("o_wb_sel", 4'b0101, mon_sel[0]);
                check_value("o_wb_we", 1, mon_we[0]);
        end
        check_value("uncached memory word", shadow[8'hc0], mem[8'hc0]);
        clear_monitor();
        cpu_access(1'b0, 32'h300, '0, 4'hf, retries);
        check_value("uncached read beats", 1, mon_adr.size());
        if (mon_adr.size() == 1)
        begin
                check_value("o_wb_cti", CTI_CLASSIC, mon_cti[0]);
                check_value("o_wb_adr", 32'h300, mon_adr[0]);
                check_value("o_wb_sel", 4'hf, mon_sel[0]);
                check_value("o_wb_we", 0, mon_we[0]);
        end
        @(negedge i_clk);
        i_cache_en = 1'b1;
        end_test("test 4 uncached access", errs);

        errs = n_errors;
        cpu_access(1'b0, 32'h384, '0, 4'hf, retries);   // Line now clean in cache
        @(negedge i_clk);
        mem[8'he1]    = ~mem[8'he1];                    // Backdoor change
        shadow[8'he1] = mem[8'he1];
        i_cache_inv   = 1'b1;
        @(posedge i_clk);
        @(negedge i_clk);
        i_cache_inv = 1'b0;
        seen        = 1'b0;
        for (int n = 0; n < 4 && !seen; n++)
        begin
                @(posedge i_clk);
                if (o_cache_inv_done)
                        seen = 1'b1;
        end
        n_accesses++;
        check_value("o_cache_inv_done", 1, seen);
        clear_monitor();
        cpu_access(1'b0, 32'h384, '0, 4'hf, retries);
        check_value("retry after invalidate", 1, retries != 0);
        check_value("refill beat count", LINE_WORDS, mon_adr.size());
        end_test("test 5 invalidate", errs);

        $display("accesses %0d, checks %0d, errors %0d", n_accesses, n_checks, n_errors);
        if (n_errors == 0)
                $display(">>> PASS");
        else
                $display(">>> FAIL");
        $finish;
end

endmodule

`default_nettype wire

//--- src.f
design/cache_geom_pkg.sv
design/wb_pkg.sv
design/store_if.sv
design/wb_req_if.sv
design/line_store.sv
design/wb_master.sv
design/cache_fsm.sv
design/cache_top.sv
dv/tb_cache.sv

//--- Makefile
# Verilator build and run of the data cache testbench

SRCS = $(wildcard design/*.sv dv/*.sv)

obj_dir/Vtb_cache: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f src.f

run: obj_dir/Vtb_cache
	./obj_dir/Vtb_cache | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
